// File: Makefile
TOP = xadac_vload_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/100ps -j 0 --top-module $(TOP) -f flist.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "Everything OK"

clean:
	rm -rf obj_dir

// File: flist.f
xadac_pkg.sv
xadac_vload_issue.sv
xadac_vload_slot.sv
xadac_vload_retire.sv
xadac_vload.sv
xadac_vload_tb.sv

// File: xadac_pkg.sv
`default_nettype none

package xadac_pkg;

    // Request id and scoreboard size
    localparam int unsigned IdWidth   = 2;
    localparam int unsigned NoEntries = 2 ** IdWidth;

    // Memory and vector geometry
    localparam int unsigned AddrWidth   = 32;
    localparam int unsigned VectorWidth = 128;
    localparam int unsigned ElemWidth   = 32;
    localparam int unsigned ElemCount   = VectorWidth / ElemWidth;

    // Replication count carried with each request
    localparam int unsigned ImmWidth = 3;

    // Scoreboard slot phases
    localparam logic [1:0] SlotFree     = 2'd0;
    localparam logic [1:0] SlotWaitGnt  = 2'd1;
    localparam logic [1:0] SlotWaitData = 2'd2;
    localparam logic [1:0] SlotReady    = 2'd3;

    typedef logic [IdWidth-1:0]   id_t;
    typedef logic [AddrWidth-1:0] addr_t;
    typedef logic [ImmWidth-1:0]  imm_t;
    typedef logic [ElemWidth-1:0] elem_t;

    // One vector word, seen either as raw memory data or as elements
    typedef union packed {
        logic [VectorWidth-1:0]  word;
        elem_t [ElemCount-1:0]   elem;
    } vector_u;

endpackage

`default_nettype wire

// File: xadac_vload.sv
`timescale 1ns/100ps
`default_nettype none

module xadac_vload (
    input  logic                 clk,
    input  logic                 rstn,

    // Request channel
    input  logic                 req_valid,
    input  xadac_pkg::id_t       req_id,
    input  xadac_pkg::addr_t     req_rs1,
    input  xadac_pkg::imm_t      req_imm,
    output logic                 req_ready,

    // Response channel
    output logic                 resp_valid,
    output xadac_pkg::id_t       resp_id,
    output xadac_pkg::vector_u   resp_vd,
    input  logic                 resp_ready,

    // Memory address channel
    output logic                 obi_req,
    output xadac_pkg::addr_t     obi_addr,
    output xadac_pkg::id_t       obi_aid,
    input  logic                 obi_gnt,

    // Memory reply channel
    input  logic                 obi_rvalid,
    input  xadac_pkg::id_t       obi_rid,
    input  xadac_pkg::vector_u   obi_rdata
);

    import xadac_pkg::*;

    // Feeder to slots
    logic [NoEntries-1:0] slot_load;
    addr_t                load_addr;
    imm_t                 load_imm;
    logic [NoEntries-1:0] slot_granted;
    logic [NoEntries-1:0] slot_fill;
    vector_u              fill_data;

    // Slots to feeder and drain
    logic [NoEntries-1:0] slot_busy;
    logic [NoEntries-1:0] slot_wants_addr;
    addr_t                slot_addr [NoEntries];
    logic [NoEntries-1:0] slot_ready;
    imm_t                 slot_imm [NoEntries];
    vector_u              slot_data [NoEntries];

    // Drain to slots
    logic [NoEntries-1:0] slot_clear;

    xadac_vload_issue issue_i (
        .clk             (clk),
        .rstn            (rstn),
        .req_valid       (req_valid),
        .req_id          (req_id),
        .req_rs1         (req_rs1),
        .req_imm         (req_imm),
        .req_ready       (req_ready),
        .slot_busy       (slot_busy),
        .slot_wants_addr (slot_wants_addr),
        .slot_addr       (slot_addr),
        .slot_load       (slot_load),
        .load_addr       (load_addr),
        .load_imm        (load_imm),
        .obi_req         (obi_req),
        .obi_addr        (obi_addr),
        .obi_aid         (obi_aid),
        .obi_gnt         (obi_gnt),
        .obi_rvalid      (obi_rvalid),
        .obi_rid         (obi_rid),
        .obi_rdata       (obi_rdata),
        .slot_granted    (slot_granted),
        .slot_fill       (slot_fill),
        .fill_data       (fill_data)
    );

    // One scoreboard slot per id
    for (genvar g = 0; g < NoEntries; g++) begin : gen_slot
        xadac_vload_slot slot_i (
            .clk        (clk),
            .rstn       (rstn),
            .load       (slot_load[g]),
            .load_addr  (load_addr),
            .load_imm   (load_imm),
            .granted    (slot_granted[g]),
            .fill       (slot_fill[g]),
            .fill_data  (fill_data),
            .clear      (slot_clear[g]),
            .busy       (slot_busy[g]),
            .wants_addr (slot_wants_addr[g]),
            .addr       (slot_addr[g]),
            .ready      (slot_ready[g]),
            .imm        (slot_imm[g]),
            .data       (slot_data[g])
        );
    end

    xadac_vload_retire retire_i (
        .clk        (clk),
        .rstn       (rstn),
        .slot_ready (slot_ready),
        .slot_imm   (slot_imm),
        .slot_data  (slot_data),
        .slot_clear (slot_clear),
        .resp_valid (resp_valid),
        .resp_id    (resp_id),
        .resp_vd    (resp_vd),
        .resp_ready (resp_ready)
    );

endmodule

`default_nettype wire

// File: xadac_vload_issue.sv
`timescale 1ns/100ps
`default_nettype none

module xadac_vload_issue (
    input  logic                               clk,
    input  logic                               rstn,

    // Request channel
    input  logic                               req_valid,
    input  xadac_pkg::id_t                     req_id,
    input  xadac_pkg::addr_t                   req_rs1,
    input  xadac_pkg::imm_t                    req_imm,
    output logic                               req_ready,

    // Slot status
    input  logic [xadac_pkg::NoEntries-1:0]    slot_busy,
    input  logic [xadac_pkg::NoEntries-1:0]    slot_wants_addr,
    input  xadac_pkg::addr_t                   slot_addr [xadac_pkg::NoEntries],

    // Slot load
    output logic [xadac_pkg::NoEntries-1:0]    slot_load,
    output xadac_pkg::addr_t                   load_addr,
    output xadac_pkg::imm_t                    load_imm,

    // Memory address channel
    output logic                               obi_req,
    output xadac_pkg::addr_t                   obi_addr,
    output xadac_pkg::id_t                     obi_aid,
    input  logic                               obi_gnt,

    // Memory reply channel
    input  logic                               obi_rvalid,
    input  xadac_pkg::id_t                     obi_rid,
    input  xadac_pkg::vector_u                 obi_rdata,

    // Slot progress strobes
    output logic [xadac_pkg::NoEntries-1:0]    slot_granted,
    output logic [xadac_pkg::NoEntries-1:0]    slot_fill,
    output xadac_pkg::vector_u                 fill_data
);

    import xadac_pkg::*;

    logic pick_valid;
    id_t  pick_id;
    logic issue;

    // A request is taken only if its own slot is free
    assign req_ready = req_valid && !slot_busy[req_id];
    assign load_addr = req_rs1;
    assign load_imm  = req_imm;

    always_comb begin
        for (int i = 0; i < NoEntries; i++) begin
            slot_load[i] = req_valid && req_ready && (req_id == id_t'(i));
        end
    end

    // Lowest-numbered waiting slot wins the address channel
    always_comb begin
        pick_valid = 1'b0;
        pick_id    = '0;
        for (int i = NoEntries - 1; i >= 0; i--) begin
            if (slot_wants_addr[i]) begin
                pick_valid = 1'b1;
                pick_id    = id_t'(i);
            end
        end
    end

    // New issue only from an idle channel, so a grant costs one idle cycle
    assign issue = !obi_req && pick_valid;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            obi_req <= 1'b0;
        end else if (obi_req) begin
            if (obi_gnt) begin
                obi_req <= 1'b0;
            end
        end else if (pick_valid) begin
            obi_req <= 1'b1;
        end
    end

    // Address fields are frozen while the request waits for its grant
    always_ff @(posedge clk) begin
        if (issue) begin
            obi_addr <= slot_addr[pick_id];
            obi_aid  <= pick_id;
        end
    end

    // Grant goes back to the owner of the outstanding address; replies follow rid
    always_comb begin
        for (int i = 0; i < NoEntries; i++) begin
            slot_granted[i] = obi_req && obi_gnt && (obi_aid == id_t'(i));
            slot_fill[i]    = obi_rvalid && (obi_rid == id_t'(i));
        end
    end

    assign fill_data = obi_rdata;

endmodule

`default_nettype wire

// File: xadac_vload_retire.sv
`timescale 1ns/100ps
`default_nettype none

module xadac_vload_retire (
    input  logic                               clk,
    input  logic                               rstn,

    // Finished slots
    input  logic [xadac_pkg::NoEntries-1:0]    slot_ready,
    input  xadac_pkg::imm_t                    slot_imm [xadac_pkg::NoEntries],
    input  xadac_pkg::vector_u                 slot_data [xadac_pkg::NoEntries],
    output logic [xadac_pkg::NoEntries-1:0]    slot_clear,

    // Response channel
    output logic                               resp_valid,
    output xadac_pkg::id_t                     resp_id,
    output xadac_pkg::vector_u                 resp_vd,
    input  logic                               resp_ready
);

    import xadac_pkg::*;

    logic    sel_valid;
    id_t     sel_id;
    imm_t    sel_imm;
    vector_u sel_data;
    vector_u rep_vd;
    logic    load_resp;

    // The held slot is released in the cycle its response is taken
    always_comb begin
        for (int i = 0; i < NoEntries; i++) begin
            slot_clear[i] = resp_valid && resp_ready && (resp_id == id_t'(i));
        end
    end

    // Lowest ready slot, skipping the one being released
    always_comb begin
        sel_valid = 1'b0;
        sel_id    = '0;
        for (int i = NoEntries - 1; i >= 0; i--) begin
            if (slot_ready[i] && !slot_clear[i]) begin
                sel_valid = 1'b1;
                sel_id    = id_t'(i);
            end
        end
    end

    assign sel_imm  = slot_imm[sel_id];
    assign sel_data = slot_data[sel_id];

    // Element i takes element (i mod imm); zero means the full vector
    always_comb begin
        int unsigned span;
        span = (sel_imm == '0) ? ElemCount : int'(sel_imm);
        for (int i = 0; i < ElemCount; i++) begin
            rep_vd.elem[i] = sel_data.elem[i % span];
        end
    end

    assign load_resp = sel_valid && (!resp_valid || resp_ready);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            resp_valid <= 1'b0;
        end else if (load_resp) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    // Response fields stay put until accepted
    always_ff @(posedge clk) begin
        if (load_resp) begin
            resp_id <= sel_id;
            resp_vd <= rep_vd;
        end
    end

endmodule

`default_nettype wire

// File: xadac_vload_slot.sv
`timescale 1ns/100ps
`default_nettype none

module xadac_vload_slot (
    input  logic                 clk,
    input  logic                 rstn,

    // Request load from the feeder
    input  logic                 load,
    input  xadac_pkg::addr_t     load_addr,
    input  xadac_pkg::imm_t      load_imm,

    // Memory progress
    input  logic                 granted,
    input  logic                 fill,
    input  xadac_pkg::vector_u   fill_data,

    // Retirement
    input  logic                 clear,

    // Slot status and contents
    output logic                 busy,
    output logic                 wants_addr,
    output xadac_pkg::addr_t     addr,
    output logic                 ready,
    output xadac_pkg::imm_t      imm,
    output xadac_pkg::vector_u   data
);

    import xadac_pkg::*;

    logic [1:0] state;

    // Free, then address pending, then data pending, then ready to retire
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= SlotFree;
        end else begin
            case (state)
                SlotFree: begin
                    if (load) begin
                        state <= SlotWaitGnt;
                    end
                end
                SlotWaitGnt: begin
                    if (granted) begin
                        state <= SlotWaitData;
                    end
                end
                SlotWaitData: begin
                    if (fill) begin
                        state <= SlotReady;
                    end
                end
                SlotReady: begin
                    if (clear) begin
                        state <= SlotFree;
                    end
                end
                default: begin
                    state <= SlotFree;
                end
            endcase
        end
    end

    // Request fields are captured once per load
    always_ff @(posedge clk) begin
        if (load && (state == SlotFree)) begin
            addr <= load_addr;
            imm  <= load_imm;
        end
    end

    // Read data arrives only after the address was granted
    always_ff @(posedge clk) begin
        if (fill && (state == SlotWaitData)) begin
            data <= fill_data;
        end
    end

    assign busy       = (state != SlotFree);
    assign wants_addr = (state == SlotWaitGnt);
    assign ready      = (state == SlotReady);

endmodule

`default_nettype wire

// File: xadac_vload_tb.sv
`timescale 1ns/100ps
`default_nettype none

module xadac_vload_tb;

    import xadac_pkg::*;

    localparam int ClkPeriod  = 20;
    localparam int WaitCycles = 200;

    logic    clk;
    logic    rstn;
    logic    req_valid;
    id_t     req_id;
    addr_t   req_rs1;
    imm_t    req_imm;
    logic    req_ready;
    logic    resp_valid;
    id_t     resp_id;
    vector_u resp_vd;
    logic    resp_ready;
    logic    obi_req;
    addr_t   obi_addr;
    id_t     obi_aid;
    logic    obi_gnt;
    logic    obi_rvalid;
    id_t     obi_rid;
    vector_u obi_rdata;

    integer  seed = 42;

    // Trace contents
    vector_u mem [addr_t];
    id_t     tr_id [$];
    addr_t   tr_addr [$];
    imm_t    tr_imm [$];
    vector_u tr_vd [$];
    int      req_idx;
    logic    hold_resp;

    // Scoreboard and memory model state owned by the bus process
    logic [NoEntries-1:0] pending;
    logic [NoEntries-1:0] awaiting_gnt;
    addr_t   exp_addr [NoEntries];
    vector_u exp_vd [NoEntries];
    int      retire_total;
    int      gnt_delay;
    int      rsp_delay;
    id_t     reply_id [$];
    addr_t   reply_addr [$];
    logic    addr_wait;
    addr_t   held_addr;
    id_t     held_aid;
    logic    resp_wait;
    id_t     held_resp_id;
    vector_u held_resp_vd;
    logic    next_gnt;
    logic    next_rvalid;
    logic    next_ready;
    id_t     next_rid;
    vector_u next_rdata;

    xadac_vload xadac_vload_i (
        .clk        (clk),
        .rstn       (rstn),
        .req_valid  (req_valid),
        .req_id     (req_id),
        .req_rs1    (req_rs1),
        .req_imm    (req_imm),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_id    (resp_id),
        .resp_vd    (resp_vd),
        .resp_ready (resp_ready),
        .obi_req    (obi_req),
        .obi_addr   (obi_addr),
        .obi_aid    (obi_aid),
        .obi_gnt    (obi_gnt),
        .obi_rvalid (obi_rvalid),
        .obi_rid    (obi_rid),
        .obi_rdata  (obi_rdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(ClkPeriod / 2) clk = ~clk;
        end
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_vector(input string name, input vector_u got, input vector_u exp);
        if (got !== exp)
            stop_on_error($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                    $time, name, got.word, exp.word));
    endtask

    task automatic check_id(input string name, input id_t got, input id_t exp);
        if (got !== exp)
            stop_on_error($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                    $time, name, got, exp));
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp)
            stop_on_error($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                    $time, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_on_error($sformatf("MISMATCH at %0t: %s got %b expected %b",
                                    $time, name, got, exp));
    endtask

    // M lines fill memory and R lines hold a request and its expected vector
    task automatic read_trace();
        int           fd;
        int           n;
        string        line;
        logic [31:0]  f_id;
        logic [31:0]  f_imm;
        addr_t        f_addr;
        logic [127:0] f_word;
        fd = $fopen("xadac_vload_trace.txt", "r");
        if (fd == 0)
            stop_on_error("Could not open xadac_vload_trace.txt");
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) == "M") begin
                n = $sscanf(line, "M %h %h", f_addr, f_word);
                mem[f_addr] = f_word;
            end else if (n > 0 && line.getc(0) == "R") begin
                n = $sscanf(line, "R %h %h %h %h", f_id, f_addr, f_imm, f_word);
                tr_id.push_back(id_t'(f_id));
                tr_addr.push_back(f_addr);
                tr_imm.push_back(imm_t'(f_imm));
                tr_vd.push_back(f_word);
            end
        end
        $fclose(fd);
        if (tr_id.size() == 0)
            stop_on_error("The trace holds no requests");
    endtask

    task automatic observe_response();
        if (resp_wait) begin
            check_bit("resp_valid", resp_valid, 1'b1);
            check_id("resp_id", resp_id, held_resp_id);
            check_vector("resp_vd", resp_vd, held_resp_vd);
        end
        resp_wait    = resp_valid && !resp_ready;
        held_resp_id = resp_id;
        held_resp_vd = resp_vd;
        if (resp_valid && resp_ready) begin
            if (!pending[resp_id] || awaiting_gnt[resp_id])
                stop_on_error($sformatf("Response for id %0d that was never fetched", resp_id));
            check_vector("resp_vd", resp_vd, exp_vd[resp_id]);
            pending[resp_id] = 1'b0;
            retire_total++;
        end
    endtask

    // Fields must hold until granted, and the aid must belong to a waiting request
    task automatic observe_address();
        if (addr_wait) begin
            check_bit("obi_req", obi_req, 1'b1);
            check_addr("obi_addr", obi_addr, held_addr);
            check_id("obi_aid", obi_aid, held_aid);
        end
        if (obi_req) begin
            if (!awaiting_gnt[obi_aid])
                stop_on_error($sformatf("Address issued for id %0d with no request waiting",
                                        obi_aid));
            check_addr("obi_addr", obi_addr, exp_addr[obi_aid]);
        end
        next_gnt = 1'b0;
        addr_wait = obi_req && !obi_gnt;
        held_addr = obi_addr;
        held_aid  = obi_aid;
        if (obi_req && obi_gnt) begin
            awaiting_gnt[obi_aid] = 1'b0;
            reply_id.push_back(obi_aid);
            reply_addr.push_back(obi_addr);
            gnt_delay = -1;
        end else if (obi_req) begin
            if (gnt_delay < 0)
                gnt_delay = $random(seed) & 3;
            if (gnt_delay == 0)
                next_gnt = 1'b1;
            else
                gnt_delay--;
        end
    endtask

    task automatic observe_request();
        if (req_valid && req_ready) begin
            if (pending[req_id])
                stop_on_error($sformatf("Request accepted for busy id %0d", req_id));
            pending[req_id]      = 1'b1;
            awaiting_gnt[req_id] = 1'b1;
            exp_addr[req_id]     = req_rs1;
            exp_vd[req_id]       = tr_vd[req_idx];
        end
    endtask

    // Replies leave in grant order after a random gap
    task automatic plan_reply();
        next_rvalid = 1'b0;
        if (reply_id.size() > 0) begin
            if (rsp_delay < 0)
                rsp_delay = $random(seed) & 3;
            if (rsp_delay == 0) begin
                if (!mem.exists(reply_addr[0]))
                    stop_on_error($sformatf("Read from unloaded address %h", reply_addr[0]));
                next_rvalid = 1'b1;
                next_rid    = reply_id.pop_front();
                next_rdata  = mem[reply_addr.pop_front()];
                rsp_delay   = -1;
            end else begin
                rsp_delay--;
            end
        end
    endtask

    // Memory and response side is sampled at the edge and driven 1 ns later
    initial begin
        obi_gnt = 1'b0;
        obi_rvalid = 1'b0;
        obi_rid = '0;
        obi_rdata = '0;
        resp_ready = 1'b0;
        pending = '0;
        awaiting_gnt = '0;
        retire_total = 0;
        gnt_delay = -1;
        rsp_delay = -1;
        addr_wait = 1'b0;
        resp_wait = 1'b0;
        next_gnt = 1'b0;
        next_rvalid = 1'b0;
        next_ready = 1'b0;
        next_rid = '0;
        next_rdata = '0;
        forever begin
            @(posedge clk);
            if (rstn) begin
                observe_response();
                observe_address();
                observe_request();
                plan_reply();
                next_ready = !hold_resp && (($random(seed) & 3) != 0);
            end
            #1;
            obi_gnt    = next_gnt;
            obi_rvalid = next_rvalid;
            obi_rid    = next_rid;
            obi_rdata  = next_rdata;
            resp_ready = next_ready;
        end
    end

    task automatic present_request(input int idx);
        req_idx   = idx;
        req_valid = 1'b1;
        req_id    = tr_id[idx];
        req_rs1   = tr_addr[idx];
        req_imm   = tr_imm[idx];
    endtask

    task automatic wait_accept();
        int   cycles;
        logic accepted;
        cycles   = 0;
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            accepted = req_ready;
            cycles++;
            if (!accepted && cycles >= WaitCycles)
                stop_on_error($sformatf("Timeout waiting for req_ready on id %0d", req_id));
        end
    endtask

    task automatic send_request(input int idx);
        present_request(idx);
        wait_accept();
        #1;
        req_valid = 1'b0;
    endtask

    task automatic wait_retired();
        int cycles;
        cycles = 0;
        while (pending != '0) begin
            @(posedge clk);
            #1;
            cycles++;
            if (pending != '0 && cycles >= WaitCycles)
                stop_on_error("Timeout waiting for outstanding responses");
        end
    endtask

    // A held response keeps its id blocked for new requests
    task automatic back_pressure_check(input int idx);
        int   cycles;
        int   retired_before;
        logic seen;
        hold_resp = 1'b1;
        send_request(idx);
        cycles = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(posedge clk);
            seen = resp_valid;
            cycles++;
            if (!seen && cycles >= WaitCycles)
                stop_on_error("Timeout waiting for resp_valid under back-pressure");
        end
        check_id("resp_id", resp_id, tr_id[idx]);
        #1;
        retired_before = retire_total;
        present_request(idx);
        repeat (6) begin
            @(posedge clk);
            check_bit("req_ready", req_ready, 1'b0);
            check_bit("resp_valid", resp_valid, 1'b1);
        end
        #1;
        hold_resp = 1'b0;
        wait_accept();
        if (retire_total == retired_before)
            stop_on_error("Repeated id was accepted before its response was taken");
        #1;
        req_valid = 1'b0;
    endtask

    initial begin
        rstn      = 1'b0;
        req_valid = 1'b0;
        req_id    = '0;
        req_rs1   = '0;
        req_imm   = '0;
        req_idx   = 0;
        hold_resp = 1'b0;
        read_trace();
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(posedge clk);
        check_bit("req_ready", req_ready, 1'b0);
        check_bit("obi_req", obi_req, 1'b0);
        check_bit("resp_valid", resp_valid, 1'b0);
        #1;
        // Stream the whole trace while repeated ids wait for their slot
        for (int i = 0; i < tr_id.size(); i++) begin
            send_request(i);
        end
        wait_retired();
        back_pressure_check(0);
        wait_retired();
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: xadac_vload_trace.txt
# M <address> <128-bit word, element 3 first>
# R <id> <address> <imm> <expected 128-bit response, element 3 first>
M 00001000 a0a0a003a0a0a002a0a0a001a0a0a000
M 00001010 b1b1b003b1b1b002b1b1b001b1b1b000
M 00001020 c2c2c003c2c2c002c2c2c001c2c2c000
M 00001030 d3d3d003d3d3d002d3d3d001d3d3d000
M 00002000 0000000f0000000e0000000d0000000c
M 00002010 89abcdef76543210fedcba9801234567
M 00003000 deadbeefcafef00d12345678aaaa5555
M 00003010 ffffffff00000001800000007fffffff
# Full vector, imm 0 and 4
R 0 00001000 0 a0a0a003a0a0a002a0a0a001a0a0a000
R 1 00001010 4 b1b1b003b1b1b002b1b1b001b1b1b000
# Replication with imm 1, 2 and 3
R 2 00001020 1 c2c2c000c2c2c000c2c2c000c2c2c000
R 3 00001030 2 d3d3d001d3d3d000d3d3d001d3d3d000
R 0 00002000 3 0000000c0000000e0000000d0000000c
# Ids out of order, so grants and replies differ from request order
R 3 00002010 0 89abcdef76543210fedcba9801234567
R 1 00003000 2 12345678aaaa555512345678aaaa5555
R 2 00003010 3 7fffffff00000001800000007fffffff
R 0 00001030 7 d3d3d003d3d3d002d3d3d001d3d3d000
# Mixed imm, with a repeated id back to back
R 2 00002010 1 01234567012345670123456701234567
R 1 00001000 2 a0a0a001a0a0a000a0a0a001a0a0a000
R 3 00003010 1 7fffffff7fffffff7fffffff7fffffff
R 0 00003000 3 aaaa5555cafef00d12345678aaaa5555
R 0 00001010 2 b1b1b001b1b1b000b1b1b001b1b1b000
R 1 00002000 0 0000000f0000000e0000000d0000000c
